// File: compile.f
hdl/cpu_types_pkg.sv
hdl/datapath_pkg.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/alu.sv
hdl/pc_unit.sv
hdl/request_unit.sv
hdl/datapath.sv
verification/datapath_sva.sv
verification/datapath_tb.sv

// File: hdl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
   import cpu_types_pkg::*;
(
   input  word_t    op1,
   input  word_t    op2,
   input  regbits_t shamt,
   input  aluop_t   opcode,
   output word_t    res,
   output logic     flag_n,
   output logic     flag_v,
   output logic     flag_z
);

   always_comb begin
      res    = '0;
      flag_v = 1'b0;
      case (opcode)
         // shifts act on the rt operand
         ALU_SLL:  res = op2 << shamt;
         ALU_SRL:  res = op2 >> shamt;
         ALU_ADD: begin
            res    = op1 + op2;
            flag_v = (op1[31] == op2[31]) && (res[31] != op1[31]);
         end
         ALU_SUB: begin
            res    = op1 - op2;
            flag_v = (op1[31] != op2[31]) && (res[31] != op1[31]);
         end
         ALU_AND:  res = op1 & op2;
         ALU_OR:   res = op1 | op2;
         ALU_XOR:  res = op1 ^ op2;
         ALU_NOR:  res = ~(op1 | op2);
         ALU_SLT:  res = {31'd0, $signed(op1) < $signed(op2)};
         ALU_SLTU: res = {31'd0, op1 < op2};
         default:  res = '0;
      endcase
   end

   assign flag_n = res[31];
   assign flag_z = (res == '0);

endmodule

`default_nettype wire

// File: hdl/control_unit.sv
`timescale 1ns/1ns
`default_nettype none

module control_unit
   import cpu_types_pkg::*;
   import datapath_pkg::*;
(
   input  word_t      instr,
   input  logic [2:0] flags,
   output ctrl_t      ctrl
);

   r_type_t rinstr;
   i_type_t iinstr;
   j_type_t jinstr;
   logic    flag_z;

   assign rinstr = instr;
   assign iinstr = instr;
   assign jinstr = instr;

   // flags arrive as {negative, overflow, zero}
   assign flag_z = flags[0];

   always_comb begin
      // fields pass straight through
      ctrl.rs        = rinstr.rs;
      ctrl.rt        = rinstr.rt;
      ctrl.rd        = rinstr.rd;
      ctrl.shamt     = rinstr.shamt;
      ctrl.imm16     = iinstr.imm;
      ctrl.jaddr26   = jinstr.addr;

      ctrl.alu_op    = ALU_ADD;
      ctrl.alu_src   = SRC_REG;
      ctrl.extop     = 1'b0;
      ctrl.regdst    = 1'b0;
      ctrl.memtoreg  = 1'b0;
      ctrl.jal       = 1'b0;
      ctrl.regwr     = 1'b0;
      ctrl.dren      = 1'b0;
      ctrl.dwen      = 1'b0;
      ctrl.pc_src    = PC_SEQ;
      ctrl.branch_ne = 1'b0;
      ctrl.halt      = 1'b0;

      case (rinstr.opcode)
         RTYPE: begin
            ctrl.regwr = 1'b1;
            case (rinstr.funct)
               SLL:  ctrl.alu_op = ALU_SLL;
               SRL:  ctrl.alu_op = ALU_SRL;
               ADDU: ctrl.alu_op = ALU_ADD;
               SUBU: ctrl.alu_op = ALU_SUB;
               AND:  ctrl.alu_op = ALU_AND;
               OR:   ctrl.alu_op = ALU_OR;
               XOR:  ctrl.alu_op = ALU_XOR;
               NOR:  ctrl.alu_op = ALU_NOR;
               SLT:  ctrl.alu_op = ALU_SLT;
               SLTU: ctrl.alu_op = ALU_SLTU;
               JR: begin
                  ctrl.regwr  = 1'b0;
                  ctrl.pc_src = PC_REG;
               end
               default: ctrl.regwr = 1'b0;
            endcase
         end
         ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI, LW: begin
            ctrl.regwr   = 1'b1;
            ctrl.regdst  = 1'b1;
            ctrl.alu_src = SRC_IMM;
            case (rinstr.opcode)
               ADDIU: ctrl.extop = 1'b1;
               SLTI: begin
                  ctrl.alu_op = ALU_SLT;
                  ctrl.extop  = 1'b1;
               end
               // sltiu sign extends yet compares unsigned
               SLTIU: begin
                  ctrl.alu_op = ALU_SLTU;
                  ctrl.extop  = 1'b1;
               end
               ANDI: ctrl.alu_op = ALU_AND;
               ORI:  ctrl.alu_op = ALU_OR;
               XORI: ctrl.alu_op = ALU_XOR;
               LUI:  ctrl.alu_src = SRC_LUI;
               default: begin
                  ctrl.extop    = 1'b1;
                  ctrl.memtoreg = 1'b1;
                  ctrl.dren     = 1'b1;
               end
            endcase
         end
         SW: begin
            ctrl.alu_src = SRC_IMM;
            ctrl.extop   = 1'b1;
            ctrl.dwen    = 1'b1;
         end
         BEQ, BNE: begin
            ctrl.alu_op    = ALU_SUB;
            ctrl.branch_ne = (rinstr.opcode == BNE);
            // taken when zero matches the branch sense
            ctrl.pc_src    = (flag_z ^ ctrl.branch_ne) ? PC_BR : PC_SEQ;
         end
         J:    ctrl.pc_src = PC_JMP;
         JAL: begin
            ctrl.pc_src = PC_JMP;
            ctrl.jal    = 1'b1;
            ctrl.regwr  = 1'b1;
         end
         HALT: ctrl.halt = 1'b1;
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

   // halt opcode of all ones
   localparam logic [5:0] HALT_OP = 6'b111111;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  regbits_t;

   typedef enum logic [5:0] {
      RTYPE = 6'b000000,
      J     = 6'b000010,
      JAL   = 6'b000011,
      BEQ   = 6'b000100,
      BNE   = 6'b000101,
      ADDIU = 6'b001001,
      SLTI  = 6'b001010,
      SLTIU = 6'b001011,
      ANDI  = 6'b001100,
      ORI   = 6'b001101,
      XORI  = 6'b001110,
      LUI   = 6'b001111,
      LW    = 6'b100011,
      SW    = 6'b101011,
      HALT  = HALT_OP
   } opcode_t;

   typedef enum logic [5:0] {
      SLL  = 6'b000000,
      SRL  = 6'b000010,
      JR   = 6'b001000,
      ADDU = 6'b100001,
      SUBU = 6'b100011,
      AND  = 6'b100100,
      OR   = 6'b100101,
      XOR  = 6'b100110,
      NOR  = 6'b100111,
      SLT  = 6'b101010,
      SLTU = 6'b101011
   } funct_t;

   typedef enum logic [3:0] {
      ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
      ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
   } aluop_t;

   // instruction views
   typedef struct packed {
      opcode_t  opcode;
      regbits_t rs;
      regbits_t rt;
      regbits_t rd;
      regbits_t shamt;
      funct_t   funct;
   } r_type_t;

   typedef struct packed {
      opcode_t     opcode;
      regbits_t    rs;
      regbits_t    rt;
      logic [15:0] imm;
   } i_type_t;

   typedef struct packed {
      opcode_t     opcode;
      logic [25:0] addr;
   } j_type_t;

   localparam word_t PC_INIT = 32'h0000_0000;

endpackage

`default_nettype wire

// File: hdl/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath
   import cpu_types_pkg::*;
   import datapath_pkg::*;
(
   input  logic    CLK,
   input  logic    reset,
   input  dp_rsp_t rsp,
   output dp_req_t req
);

   ctrl_t    ctrl;
   word_t    rdat1;
   word_t    rdat2;
   word_t    op2;
   word_t    alu_res;
   word_t    wdat;
   word_t    pc;
   word_t    pc_plus4;
   regbits_t wsel;
   logic     flag_n;
   logic     flag_v;
   logic     flag_z;
   logic     wen;
   logic     pc_stall;
   logic     pcEN;
   logic     dmemREN;
   logic     dmemWEN;
   logic     halted_q;

   control_unit CU (
      .instr (rsp.imemload),
      .flags ({flag_n, flag_v, flag_z}),
      .ctrl  (ctrl)
   );

   register_file RF (
      .CLK   (CLK),
      .reset (reset),
      .wen   (wen),
      .wsel  (wsel),
      .wdat  (wdat),
      .rsel1 (ctrl.rs),
      .rsel2 (ctrl.rt),
      .rdat1 (rdat1),
      .rdat2 (rdat2)
   );

   alu ALU (
      .op1    (rdat1),
      .op2    (op2),
      .shamt  (ctrl.shamt),
      .opcode (ctrl.alu_op),
      .res    (alu_res),
      .flag_n (flag_n),
      .flag_v (flag_v),
      .flag_z (flag_z)
   );

   pc_unit PC (
      .CLK      (CLK),
      .reset    (reset),
      .pcEN     (pcEN),
      .halt     (ctrl.halt),
      .pc_src   (ctrl.pc_src),
      .imm16    (ctrl.imm16),
      .jaddr26  (ctrl.jaddr26),
      .rdat1    (rdat1),
      .pc       (pc),
      .pc_plus4 (pc_plus4)
   );

   // strobes and writes are masked once halted
   request_unit RQ (
      .CLK      (CLK),
      .reset    (reset),
      .ihit     (rsp.ihit),
      .dhit     (rsp.dhit),
      .dren     (ctrl.dren && !halted_q),
      .dwen     (ctrl.dwen && !halted_q),
      .regwr    (ctrl.regwr && !halted_q),
      .dmemREN  (dmemREN),
      .dmemWEN  (dmemWEN),
      .wen      (wen),
      .pc_stall (pc_stall)
   );

   assign pcEN = rsp.ihit && !pc_stall;

   // second operand with lui placing imm in the upper half
   always_comb begin
      case (ctrl.alu_src)
         SRC_IMM: op2 = ctrl.extop ? {{16{ctrl.imm16[15]}}, ctrl.imm16}
                                   : {16'd0, ctrl.imm16};
         SRC_LUI: op2 = {ctrl.imm16, 16'd0};
         default: op2 = rdat2;
      endcase
   end

   // write back
   assign wsel = ctrl.jal ? 5'd31 : (ctrl.regdst ? ctrl.rt : ctrl.rd);
   assign wdat = ctrl.memtoreg ? rsp.dmemload : (ctrl.jal ? pc_plus4 : alu_res);

   // sticky halt set when the halt instruction is fetched
   always_ff @(posedge CLK) begin
      if (reset) begin
         halted_q <= 1'b0;
      end else if (ctrl.halt && rsp.ihit) begin
         halted_q <= 1'b1;
      end
   end

   assign req.imemREN   = !halted_q;
   assign req.imemaddr  = pc;
   assign req.dmemREN   = dmemREN;
   assign req.dmemWEN   = dmemWEN;
   assign req.dmemaddr  = alu_res;
   assign req.dmemstore = rdat2;
   assign req.halt      = halted_q;

endmodule

`default_nettype wire

// File: hdl/datapath_pkg.sv
`default_nettype none

package datapath_pkg;
   import cpu_types_pkg::*;

   // second alu operand source
   typedef enum logic [1:0] {
      SRC_REG = 2'd0,
      SRC_IMM = 2'd1,
      SRC_LUI = 2'd2
   } alusrc_t;

   // next pc source
   typedef enum logic [1:0] {
      PC_SEQ = 2'd0,
      PC_BR  = 2'd1,
      PC_JMP = 2'd2,
      PC_REG = 2'd3
   } pcsrc_t;

   typedef struct packed {
      regbits_t    rs;
      regbits_t    rt;
      regbits_t    rd;
      regbits_t    shamt;
      logic [15:0] imm16;
      logic [25:0] jaddr26;
      aluop_t      alu_op;
      alusrc_t     alu_src;
      logic        extop;
      logic        regdst;
      logic        memtoreg;
      logic        jal;
      logic        regwr;
      logic        dren;
      logic        dwen;
      pcsrc_t      pc_src;
      logic        branch_ne;
      logic        halt;
   } ctrl_t;

   // datapath to caches
   typedef struct packed {
      logic  imemREN;
      word_t imemaddr;
      logic  dmemREN;
      logic  dmemWEN;
      word_t dmemaddr;
      word_t dmemstore;
      logic  halt;
   } dp_req_t;

   // caches to datapath
   typedef struct packed {
      logic  ihit;
      word_t imemload;
      logic  dhit;
      word_t dmemload;
   } dp_rsp_t;

endpackage

`default_nettype wire

// File: hdl/pc_unit.sv
`timescale 1ns/1ns
`default_nettype none

module pc_unit
   import cpu_types_pkg::*;
   import datapath_pkg::*;
(
   input  logic        CLK,
   input  logic        reset,
   input  logic        pcEN,
   input  logic        halt,
   input  pcsrc_t      pc_src,
   input  logic [15:0] imm16,
   input  logic [25:0] jaddr26,
   input  word_t       rdat1,
   output word_t       pc,
   output word_t       pc_plus4
);

   word_t br_target;
   word_t jmp_target;
   word_t pc_next;
   logic  halt_q;

   assign pc_plus4   = pc + 32'd4;
   assign br_target  = pc_plus4 + {{14{imm16[15]}}, imm16, 2'b00};
   assign jmp_target = {pc_plus4[31:28], jaddr26, 2'b00};

   always_comb begin
      case (pc_src)
         PC_BR:   pc_next = br_target;
         PC_JMP:  pc_next = jmp_target;
         PC_REG:  pc_next = rdat1;
         default: pc_next = pc_plus4;
      endcase
   end

   // pc parks on the halt instruction
   always_ff @(posedge CLK) begin
      if (reset) begin
         pc     <= PC_INIT;
         halt_q <= 1'b0;
      end else if (pcEN && !halt_q) begin
         if (halt) begin
            halt_q <= 1'b1;
         end else begin
            pc <= pc_next;
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file
   import cpu_types_pkg::*;
(
   input  logic     CLK,
   input  logic     reset,
   input  logic     wen,
   input  regbits_t wsel,
   input  word_t    wdat,
   input  regbits_t rsel1,
   input  regbits_t rsel2,
   output word_t    rdat1,
   output word_t    rdat2
);

   word_t regs [32];

   always_ff @(posedge CLK) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && (wsel != 5'd0)) begin
         regs[wsel] <= wdat;
      end
   end

   // register zero reads as zero
   assign rdat1 = (rsel1 == 5'd0) ? '0 : regs[rsel1];
   assign rdat2 = (rsel2 == 5'd0) ? '0 : regs[rsel2];

endmodule

`default_nettype wire

// File: hdl/request_unit.sv
`timescale 1ns/1ns
`default_nettype none

module request_unit (
   input  logic CLK,
   input  logic reset,
   input  logic ihit,
   input  logic dhit,
   input  logic dren,
   input  logic dwen,
   input  logic regwr,
   output logic dmemREN,
   output logic dmemWEN,
   output logic wen,
   output logic pc_stall
);

   logic mem_op;
   logic active;
   logic pending_q;
   logic blank_q;

   assign mem_op = dren | dwen;

   // no strobe in the cycle after reset or after a retired access
   assign active   = mem_op && (ihit || pending_q) && !blank_q;
   assign dmemREN  = dren && active;
   assign dmemWEN  = dwen && active;
   assign pc_stall = mem_op && (ihit || pending_q) && !(active && dhit);
   assign wen      = regwr && (ihit || pending_q) && !pc_stall;

   always_ff @(posedge CLK) begin
      if (reset) begin
         pending_q <= 1'b0;
         blank_q   <= 1'b1;
      end else begin
         pending_q <= active && !dhit;
         blank_q   <= active && dhit;
      end
   end

endmodule

`default_nettype wire

// File: verification/datapath_sva.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_sva
   import cpu_types_pkg::*;
   import datapath_pkg::*;
(
   input logic    CLK,
   input logic    reset,
   input dp_rsp_t rsp,
   input dp_req_t req
);

   int fail_count = 0;

   // read and write strobes are exclusive
   strobe_excl: assert property (@(posedge CLK) disable iff (reset)
      !(req.dmemREN && req.dmemWEN))
      else begin
         $error("dmemREN and dmemWEN high together");
         fail_count++;
      end

   // quiet bus right after reset
   reset_quiet: assert property (@(posedge CLK)
      reset |=> !req.dmemREN && !req.dmemWEN && !req.halt && req.imemREN)
      else begin
         $error("memory strobes or halt active in the cycle after reset");
         fail_count++;
      end

   // strobe held until the cache answers
   read_held: assert property (@(posedge CLK) disable iff (reset)
      req.dmemREN && !rsp.dhit |=> req.dmemREN)
      else begin
         $error("dmemREN dropped before dhit");
         fail_count++;
      end

   write_held: assert property (@(posedge CLK) disable iff (reset)
      req.dmemWEN && !rsp.dhit |=> req.dmemWEN)
      else begin
         $error("dmemWEN dropped before dhit");
         fail_count++;
      end

   // gap after a finished access
   strobe_gap: assert property (@(posedge CLK) disable iff (reset)
      (req.dmemREN || req.dmemWEN) && rsp.dhit |=> !req.dmemREN && !req.dmemWEN)
      else begin
         $error("data strobe still high in the cycle after dhit");
         fail_count++;
      end

   // halted core stays parked
   halt_parked: assert property (@(posedge CLK) disable iff (reset)
      req.halt |=> $stable(req.imemaddr))
      else begin
         $error("imemaddr moved after halt");
         fail_count++;
      end

endmodule

bind datapath datapath_sva CHK (.*);

`default_nettype wire

// File: verification/datapath_tb.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_tb
   import cpu_types_pkg::*;
   import datapath_pkg::*;
();

   localparam int TBL_LEN    = 47;
   localparam int IMEM_WORDS = 64;
   localparam int DMEM_WORDS = 256;
   localparam int CLK_PERIOD = 4;
   localparam int MAX_CYCLES = TBL_LEN * 8 + 3 + 64;

   // one program line with mem set where a data access is expected
   typedef struct packed {
      word_t instr;
      logic  mem;
   } tbl_entry_t;

   logic       CLK = 1'b0;
   logic       reset;
   dp_rsp_t    rsp = '0;
   dp_req_t    req;
   tbl_entry_t program_tbl [TBL_LEN];
   word_t      imem [IMEM_WORDS];
   word_t      dmem [DMEM_WORDS];
   word_t      ref_regs [32];
   word_t      ref_pc = PC_INIT;
   logic       ref_halted = 1'b0;
   logic       lost = 1'b0;
   int         idelay = 0;
   int         ddelay = 0;
   int         err_value = 0;
   int         err_other = 0;

   datapath UUT (
      .CLK   (CLK),
      .reset (reset),
      .rsp   (rsp),
      .req   (req)
   );

   always #(CLK_PERIOD / 2) CLK = ~CLK;

   function automatic word_t rtype_word(funct_t fn, int rd, int rs, int rt, int sh);
      return {RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
   endfunction

   function automatic word_t itype_word(opcode_t op, int rt, int rs, logic [15:0] imm);
      return {op, 5'(rs), 5'(rt), imm};
   endfunction

   function automatic word_t jump_word(opcode_t op, int target);
      return {op, 26'(target)};
   endfunction

   task automatic build_program();
      program_tbl[0]  = '{itype_word(ADDIU, 1, 0, 16'h0123), 1'b0};
      program_tbl[1]  = '{itype_word(LUI, 2, 0, 16'h8000), 1'b0};
      program_tbl[2]  = '{itype_word(ORI, 2, 2, 16'h0f0f), 1'b0};
      program_tbl[3]  = '{rtype_word(ADDU, 3, 1, 2, 0), 1'b0};
      program_tbl[4]  = '{rtype_word(SUBU, 4, 1, 2, 0), 1'b0};
      program_tbl[5]  = '{rtype_word(SLT, 5, 2, 1, 0), 1'b0};
      program_tbl[6]  = '{rtype_word(SLTU, 6, 2, 1, 0), 1'b0};
      program_tbl[7]  = '{itype_word(ADDIU, 7, 0, 16'h0200), 1'b0};
      program_tbl[8]  = '{itype_word(SW, 3, 7, 16'd0), 1'b1};
      program_tbl[9]  = '{itype_word(SW, 4, 7, 16'd4), 1'b1};
      program_tbl[10] = '{itype_word(SW, 5, 7, 16'd8), 1'b1};
      program_tbl[11] = '{itype_word(SW, 6, 7, 16'd12), 1'b1};
      program_tbl[12] = '{rtype_word(NOR, 8, 1, 2, 0), 1'b0};
      program_tbl[13] = '{rtype_word(XOR, 9, 1, 2, 0), 1'b0};
      program_tbl[14] = '{rtype_word(SLL, 10, 0, 1, 4), 1'b0};
      program_tbl[15] = '{rtype_word(SRL, 11, 0, 2, 3), 1'b0};
      program_tbl[16] = '{itype_word(SLTIU, 12, 1, 16'hffff), 1'b0};
      program_tbl[17] = '{itype_word(SLTI, 13, 2, 16'hffff), 1'b0};
      program_tbl[18] = '{itype_word(XORI, 14, 2, 16'hffff), 1'b0};
      program_tbl[19] = '{itype_word(ANDI, 15, 2, 16'h00ff), 1'b0};
      program_tbl[20] = '{itype_word(SW, 8, 7, 16'd16), 1'b1};
      program_tbl[21] = '{itype_word(SW, 9, 7, 16'd20), 1'b1};
      program_tbl[22] = '{itype_word(SW, 10, 7, 16'd24), 1'b1};
      program_tbl[23] = '{itype_word(SW, 11, 7, 16'd28), 1'b1};
      program_tbl[24] = '{itype_word(SW, 12, 7, 16'd32), 1'b1};
      program_tbl[25] = '{itype_word(SW, 13, 7, 16'd36), 1'b1};
      program_tbl[26] = '{itype_word(SW, 14, 7, 16'd40), 1'b1};
      program_tbl[27] = '{itype_word(SW, 15, 7, 16'd44), 1'b1};
      program_tbl[28] = '{itype_word(LW, 16, 7, 16'd0), 1'b1};
      program_tbl[29] = '{itype_word(LW, 17, 7, 16'h0040), 1'b1};
      program_tbl[30] = '{rtype_word(ADDU, 18, 16, 17, 0), 1'b0};
      program_tbl[31] = '{itype_word(SW, 18, 7, 16'd48), 1'b1};
      // write to r0 must vanish
      program_tbl[32] = '{itype_word(ADDIU, 0, 0, 16'd5), 1'b0};
      program_tbl[33] = '{itype_word(SW, 0, 7, 16'd52), 1'b1};
      program_tbl[34] = '{itype_word(BEQ, 1, 1, 16'd1), 1'b0};
      program_tbl[35] = '{itype_word(ADDIU, 20, 0, 16'h0bad), 1'b0};
      program_tbl[36] = '{itype_word(BNE, 1, 1, 16'd1), 1'b0};
      program_tbl[37] = '{itype_word(BNE, 2, 1, 16'd1), 1'b0};
      program_tbl[38] = '{itype_word(ADDIU, 20, 0, 16'h0bad), 1'b0};
      program_tbl[39] = '{jump_word(JAL, 42), 1'b0};
      program_tbl[40] = '{itype_word(SW, 31, 7, 16'd56), 1'b1};
      program_tbl[41] = '{jump_word(J, 44), 1'b0};
      program_tbl[42] = '{itype_word(ADDIU, 21, 1, 16'h0010), 1'b0};
      program_tbl[43] = '{rtype_word(JR, 0, 31, 0, 0), 1'b0};
      program_tbl[44] = '{itype_word(SW, 20, 7, 16'd60), 1'b1};
      program_tbl[45] = '{itype_word(SW, 21, 7, 16'd64), 1'b1};
      program_tbl[46] = '{{HALT_OP, 26'd0}, 1'b0};
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         err_value++;
      end
   endtask

   task automatic check_req(input string name, input dp_req_t got, input dp_req_t exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         err_value++;
      end
   endtask

   function automatic word_t ref_data_addr(input i_type_t ins);
      return ref_regs[ins.rs] + {{16{ins.imm[15]}}, ins.imm};
   endfunction

   // ISA reference executing one instruction per call
   task automatic execute_ref(input word_t instr);
      r_type_t  r;
      word_t    a;
      word_t    b;
      word_t    simm;
      word_t    zimm;
      word_t    res;
      word_t    addr;
      word_t    next_pc;
      logic     wr;
      regbits_t dst;
      r       = instr;
      a       = ref_regs[r.rs];
      b       = ref_regs[r.rt];
      simm    = {{16{instr[15]}}, instr[15:0]};
      zimm    = {16'd0, instr[15:0]};
      addr    = a + simm;
      next_pc = ref_pc + 32'd4;
      res     = '0;
      wr      = 1'b1;
      dst     = r.rt;
      case (r.opcode)
         RTYPE: begin
            dst = r.rd;
            case (r.funct)
               ADDU: res = a + b;
               SUBU: res = a - b;
               AND:  res = a & b;
               OR:   res = a | b;
               XOR:  res = a ^ b;
               NOR:  res = ~(a | b);
               SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               SLTU: res = (a < b) ? 32'd1 : 32'd0;
               SLL:  res = b << r.shamt;
               SRL:  res = b >> r.shamt;
               JR: begin
                  wr      = 1'b0;
                  next_pc = a;
               end
               default: wr = 1'b0;
            endcase
         end
         ADDIU: res = a + simm;
         SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
         SLTIU: res = (a < simm) ? 32'd1 : 32'd0;
         ANDI:  res = a & zimm;
         ORI:   res = a | zimm;
         XORI:  res = a ^ zimm;
         LUI:   res = {instr[15:0], 16'd0};
         LW:    res = dmem[addr[9:2]];
         BEQ, BNE: begin
            wr = 1'b0;
            if ((a == b) ^ (r.opcode == BNE)) begin
               next_pc = ref_pc + 32'd4 + (simm << 2);
            end
         end
         J, JAL: begin
            wr      = (r.opcode == JAL);
            dst     = 5'd31;
            res     = ref_pc + 32'd4;
            next_pc = {next_pc[31:28], instr[25:0], 2'b00};
         end
         default: wr = 1'b0;
      endcase
      if (wr && dst != 5'd0) begin
         ref_regs[dst] = res;
      end
      ref_pc = next_pc;
   endtask

   task automatic retire_instr(input word_t instr);
      execute_ref(instr);
      rsp.ihit <= 1'b0;
      rsp.dhit <= 1'b0;
      idelay = $urandom % 4;
      ddelay = $urandom % 4;
   endtask

   // cache models and reference checks sampled before the edge updates
   always @(posedge CLK) begin : bus_model
      i_type_t    cur;
      tbl_entry_t ent;
      dp_req_t    exp_req;
      dp_req_t    got_req;
      logic       mem_cycle;
      int         idx;
      if (reset) begin
         rsp <= '0;
         ref_pc = PC_INIT;
         for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
         end
         ref_halted = 1'b0;
         idelay = $urandom % 4;
         ddelay = $urandom % 4;
      end else if (!lost) begin
         idx = int'(ref_pc[31:2]);
         if (idx >= TBL_LEN) begin
            $display("fetch left the program, pc %h is past the last table entry", ref_pc);
            err_other++;
            lost = 1'b1;
         end else begin
            ent       = program_tbl[idx];
            cur       = ent.instr;
            mem_cycle = rsp.ihit && ent.mem && !ref_halted;

            exp_req         = '0;
            exp_req.imemREN = !ref_halted;
            exp_req.halt    = ref_halted;
            exp_req.dmemREN = mem_cycle && (cur.opcode == LW);
            exp_req.dmemWEN = mem_cycle && (cur.opcode == SW);
            // addresses and data are checked on their own
            got_req           = req;
            got_req.imemaddr  = '0;
            got_req.dmemaddr  = '0;
            got_req.dmemstore = '0;
            check_req("req", got_req, exp_req);
            check_word("imemaddr", req.imemaddr, ref_pc);
            if (mem_cycle) begin
               check_word("dmemaddr", req.dmemaddr, ref_data_addr(cur));
               if (cur.opcode == SW) begin
                  check_word("dmemstore", req.dmemstore, ref_regs[cur.rt]);
               end
            end

            if (ref_halted) begin
               idelay = 0;
            end else if (!rsp.ihit) begin
               if (idelay == 0) begin
                  rsp.ihit     <= 1'b1;
                  rsp.imemload <= imem[req.imemaddr[7:2]];
               end else begin
                  idelay--;
               end
            end else if (cur.opcode == HALT) begin
               ref_halted = 1'b1;
               rsp.ihit <= 1'b0;
            end else if (!ent.mem) begin
               retire_instr(cur);
            end else if (rsp.dhit) begin
               if (req.dmemWEN) begin
                  dmem[req.dmemaddr[9:2]] = req.dmemstore;
               end
               retire_instr(cur);
            end else if (req.dmemREN || req.dmemWEN) begin
               if (ddelay == 0) begin
                  rsp.dhit     <= 1'b1;
                  rsp.dmemload <= dmem[req.dmemaddr[9:2]];
               end else begin
                  ddelay--;
               end
            end
         end
      end
   end

   initial begin : main
      void'($urandom(32'h3e6d742a));
      reset = 1'b1;
      build_program();
      // unused words hold halt with the address in the low bits
      for (int i = 0; i < IMEM_WORDS; i++) begin
         imem[i] = (i < TBL_LEN) ? program_tbl[i].instr : {HALT_OP, 26'(i)};
      end
      for (int i = 0; i < DMEM_WORDS; i++) begin
         dmem[i] = 32'h5a5a_0000 ^ (i * 32'h0001_0203);
      end
      repeat (3) @(posedge CLK);
      reset <= 1'b0;
      wait (ref_halted || lost);
      // let the halted core sit for a few cycles
      repeat (8) @(posedge CLK);
      $display("errors: %0d value, %0d other, %0d assertion",
               err_value, err_other, UUT.CHK.fail_count);
      if (err_value + err_other + UUT.CHK.fail_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin : watchdog
      #(MAX_CYCLES * CLK_PERIOD);
      $display("timeout, halt was not reached within %0d cycles", MAX_CYCLES);
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire
